//--- hw/eth_gen_macros.svh
// Register map, length limits and payload pattern constants, included where they are needed
`ifndef ETH_GEN_MACROS_SVH
`define ETH_GEN_MACROS_SVH

// Register addresses
// ----------------------------------------
`define REG_NUMBER_PACKET 4'd0
`define REG_CONFIG        4'd1
`define REG_SRC_LO        4'd4
`define REG_SRC_HI        4'd5
`define REG_DST_LO        4'd6
`define REG_DST_HI        4'd7
`define REG_OPERATION     4'd8
`define REG_PACKET_COUNT  4'd9

// Payload length limits
// ----------------------------------------
`define LEN_HEADER_BYTES  16'd24    // Taken off pkt_length
`define LEN_MAX_PROGRAM   16'd9600  // Above this the payload is clamped
`define LEN_MAX_PAYLOAD   16'd9576  // Clamped payload length
`define LEN_FIELD_OFFSET  16'd6     // Added to L in the length field

// Incrementing byte pattern
`define PATTERN_FIRST     32'h00010203
`define PATTERN_STEP      32'h04040404
`define PATTERN_LAST      32'hFCFDFEFF

`endif

//--- hw/eth_gen_pkg.sv
// Shared types for the Ethernet frame generator, imported by the RTL and the testbench
package eth_gen_pkg;

	typedef logic [31:0] word_t;        // Stream or register word
	typedef logic [47:0] mac_addr_t;    // MAC address, byte k in bits 8k+7:8k
	typedef logic [15:0] byte_count_t;  // Payload byte count or length field
	typedef logic [15:0] seq_num_t;     // Per-frame sequence number
	typedef logic [31:0] pkt_count_t;   // Packet count
	typedef logic [3:0]  reg_addr_t;    // Register address
	typedef logic [1:0]  tx_mod_t;      // Unused bytes in the last word

	// Frame sequencing states, one per header word plus payload and gap
	typedef enum logic [2:0] {
		st_idle     = 3'd0,
		st_dest     = 3'd1,
		st_dest_src = 3'd2,
		st_src      = 3'd3,
		st_len_seq  = 3'd4,
		st_data     = 3'd5,
		st_gap      = 3'd6
	} gen_state_t;

	// Programmed settings from the register bank
	typedef struct packed {
		pkt_count_t  number_packet;   // Packets per run
		logic [13:0] pkt_length;      // Fixed frame length setting
		mac_addr_t   s_addr;          // Source address
		mac_addr_t   d_addr;          // Destination address
	} gen_settings_t;

endpackage

//--- hw/gen_regs.sv
// Register bank of the frame generator: settings, start/stop control, done status and readback
module gen_regs import eth_gen_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  reg_addr_t     address,
	input  logic          write,
	input  logic          read,
	input  word_t         writedata,
	input  pkt_count_t    packet_count,  // Frames sent since start
	input  gen_state_t    state,
	output word_t         readdata,
	output gen_settings_t settings,
	output logic          start,         // One-cycle pulse
	output logic          stop           // Level, honoured between frames
);

`include "eth_gen_macros.svh"

	logic done;     // Operation bit 2
	logic started;  // A run has been started since reset

	// Programmed registers
	// ----------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			settings <= '0;
			stop     <= 1'b0;
		end
		else if (write)
		begin
			case (address)
				`REG_NUMBER_PACKET: settings.number_packet <= writedata;
				`REG_CONFIG:        settings.pkt_length <= writedata[14:1];
				`REG_SRC_LO:        settings.s_addr[31:0] <= writedata;
				`REG_SRC_HI:        settings.s_addr[47:32] <= writedata[15:0];
				`REG_DST_LO:        settings.d_addr[31:0] <= writedata;
				`REG_DST_HI:        settings.d_addr[47:32] <= writedata[15:0];
				`REG_OPERATION:     stop <= writedata[1];
				default:            ;
			endcase
		end
	end

	// Start bit clears itself after one cycle
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			start <= 1'b0;
		else
			start <= write && (address == `REG_OPERATION) && writedata[0];
	end

	// Done once the programmed count is sent and the FSM is back in idle
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			done    <= 1'b0;
			started <= 1'b0;
		end
		else if (start)
		begin
			done    <= 1'b0;   // New run
			started <= 1'b1;
		end
		else if (started && (state == st_idle) && (packet_count == settings.number_packet))
			done <= 1'b1;
	end

	// Read mux, zero when not reading or on unused addresses
	always_comb
	begin
		readdata = '0;
		if (read)
		begin
			case (address)
				`REG_NUMBER_PACKET: readdata = settings.number_packet;
				`REG_CONFIG:        readdata = {17'd0, settings.pkt_length, 1'b0};
				`REG_SRC_LO:        readdata = settings.s_addr[31:0];
				`REG_SRC_HI:        readdata = {16'd0, settings.s_addr[47:32]};
				`REG_DST_LO:        readdata = settings.d_addr[31:0];
				`REG_DST_HI:        readdata = {16'd0, settings.d_addr[47:32]};
				`REG_OPERATION:     readdata = {29'd0, done, stop, start};
				`REG_PACKET_COUNT:  readdata = packet_count;
				default:            readdata = '0;  // Seed slots 2 and 3 included
			endcase
		end
	end

endmodule

//--- hw/gen_fsm.sv
// Frame sequencing FSM, stepping through the header words, the payload and the inter-frame gap
module gen_fsm import eth_gen_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          start,
	input  logic          stop,
	input  gen_settings_t settings,
	input  logic          tx_rdy,        // Stream advances only on ready
	input  byte_count_t   byte_count,    // Payload bytes still to load
	input  pkt_count_t    packet_count,
	output gen_state_t    state
);

	gen_state_t next_state;
	pkt_count_t sent_after;  // Count once the frame in the gap is accepted
	logic       last_frame;

	assign sent_after = packet_count + 32'd1;
	assign last_frame = stop || (sent_after >= settings.number_packet);

	// Next state
	// ----------------------------------------
	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:
				if (start)
					next_state = st_dest;
			st_dest:
				if (tx_rdy)
					next_state = st_dest_src;
			st_dest_src:
				if (tx_rdy)
					next_state = st_src;
			st_src:
				if (tx_rdy)
					next_state = st_len_seq;
			st_len_seq:
				if (tx_rdy)
					next_state = (byte_count == 16'd0) ? st_gap : st_data;  // Empty payload
			st_data:
				if (tx_rdy && (byte_count <= 16'd4))
					next_state = st_gap;    // Last payload word loaded
			st_gap:
				if (tx_rdy)
					next_state = last_frame ? st_idle : st_dest;
			default:
				next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= st_idle;
		else
			state <= next_state;
	end

endmodule

//--- hw/frame_counters.sv
// Payload length and byte counter, sequence number and sent-packet counter of the generator
module frame_counters import eth_gen_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          start,
	input  logic          tx_rdy,
	input  gen_state_t    state,
	input  gen_settings_t settings,
	output byte_count_t   byte_count,    // Payload bytes still to load
	output byte_count_t   payload_len,   // L of the current frame
	output seq_num_t      seq_num,
	output pkt_count_t    packet_count
);

`include "eth_gen_macros.svh"

	byte_count_t len_calc;

	// L from pkt_length with both clamps
	always_comb
	begin
		if (settings.pkt_length < `LEN_HEADER_BYTES)
			len_calc = '0;
		else if (settings.pkt_length > `LEN_MAX_PROGRAM)
			len_calc = `LEN_MAX_PAYLOAD;
		else
			len_calc = byte_count_t'(settings.pkt_length) - `LEN_HEADER_BYTES;
	end

	// Latched while the first header word is pending, counted down per data word
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			payload_len <= '0;
			byte_count  <= '0;
		end
		else if (state == st_dest)
		begin
			payload_len <= len_calc;
			byte_count  <= len_calc;
		end
		else if ((state == st_data) && tx_rdy)
			byte_count <= byte_count - 16'd4;  // May pass below zero on the last word
	end

	// Frame accounting, the eop word is accepted when ready is seen in the gap
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			seq_num      <= '0;
			packet_count <= '0;
		end
		else if (start)
		begin
			seq_num      <= '0;
			packet_count <= '0;
		end
		else if ((state == st_gap) && tx_rdy)
		begin
			seq_num      <= seq_num + 16'd1;
			packet_count <= packet_count + 32'd1;
		end
	end

endmodule

//--- hw/frame_builder.sv
// Output stage of the generator that builds header and payload words and registers them with marks
module frame_builder import eth_gen_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          tx_rdy,
	input  gen_state_t    state,
	input  gen_settings_t settings,
	input  byte_count_t   payload_len,
	input  seq_num_t      seq_num,
	output word_t         tx_data,
	output logic          tx_wren,
	output logic          tx_sop,
	output logic          tx_eop,
	output tx_mod_t       tx_mod
);

`include "eth_gen_macros.svh"

	word_t     pattern;     // Next payload word
	word_t     next_word;
	logic      next_wren;
	logic      next_sop;
	mac_addr_t da;
	mac_addr_t sa;
	tx_mod_t   last_mod;    // Unused bytes at the end of the payload

	assign da = settings.d_addr;
	assign sa = settings.s_addr;
	assign last_mod = 2'd0 - payload_len[1:0];

	// Word selection by state
	// ----------------------------------------
	always_comb
	begin
		next_word = '0;
		next_wren = 1'b1;
		next_sop  = 1'b0;
		case (state)
			st_dest:
			begin
				next_word = {da[7:0], da[15:8], da[23:16], da[31:24]};
				next_sop  = 1'b1;
			end
			st_dest_src: next_word = {da[39:32], da[47:40], sa[7:0], sa[15:8]};
			st_src:      next_word = {sa[23:16], sa[31:24], sa[39:32], sa[47:40]};
			st_len_seq:  next_word = {payload_len + `LEN_FIELD_OFFSET, seq_num};
			st_data:     next_word = pattern;
			default:     next_wren = 1'b0;  // Idle or gap
		endcase
	end

	// Incrementing bytes, restarted at every frame
	always_ff @(posedge clk)
	begin
		if (state == st_dest)
			pattern <= `PATTERN_FIRST;
		else if ((state == st_data) && tx_rdy)
			pattern <= (pattern == `PATTERN_LAST) ? `PATTERN_FIRST : pattern + `PATTERN_STEP;
	end

	// Output register, loads only with ready so the word holds under back-pressure
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			tx_data <= '0;
			tx_wren <= 1'b0;
			tx_sop  <= 1'b0;
		end
		else if (tx_rdy)
		begin
			tx_data <= next_word;
			tx_wren <= next_wren;
			tx_sop  <= next_sop;
		end
	end

	// The FSM sits in the gap exactly while the last word is on the output
	assign tx_eop = (state == st_gap);
	assign tx_mod = tx_eop ? last_mod : 2'd0;

endmodule

//--- hw/eth_gen.sv
// Top level of the Ethernet frame generator, a register bank feeding a MAC transmit FIFO stream
module eth_gen import eth_gen_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  reg_addr_t address,    // Register bus
	input  logic      write,
	input  logic      read,
	input  word_t     writedata,
	output word_t     readdata,
	input  logic      tx_rdy,     // Transmit FIFO side
	output word_t     tx_data,
	output logic      tx_wren,
	output logic      tx_sop,
	output logic      tx_eop,
	output tx_mod_t   tx_mod
);

	gen_settings_t settings;
	gen_state_t    state;
	logic          start;
	logic          stop;
	byte_count_t   byte_count;
	byte_count_t   payload_len;
	seq_num_t      seq_num;
	pkt_count_t    packet_count;

	// Control
	// ----------------------------------------
	gen_regs i_gen_regs (
		.clk(clk), .reset(reset), .address(address), .write(write), .read(read),
		.writedata(writedata), .packet_count(packet_count), .state(state),
		.readdata(readdata), .settings(settings), .start(start), .stop(stop)
	);

	gen_fsm i_gen_fsm (
		.clk(clk), .reset(reset), .start(start), .stop(stop), .settings(settings),
		.tx_rdy(tx_rdy), .byte_count(byte_count), .packet_count(packet_count),
		.state(state)
	);

	// Datapath
	// ----------------------------------------
	frame_counters i_frame_counters (
		.clk(clk), .reset(reset), .start(start), .tx_rdy(tx_rdy), .state(state),
		.settings(settings), .byte_count(byte_count), .payload_len(payload_len),
		.seq_num(seq_num), .packet_count(packet_count)
	);

	frame_builder i_frame_builder (
		.clk(clk), .reset(reset), .tx_rdy(tx_rdy), .state(state), .settings(settings),
		.payload_len(payload_len), .seq_num(seq_num), .tx_data(tx_data),
		.tx_wren(tx_wren), .tx_sop(tx_sop), .tx_eop(tx_eop), .tx_mod(tx_mod)
	);

endmodule

//--- bench/eth_gen_assertions.sv
// Concurrent checks on the transmit stream marks and hold behaviour, bound into the generator top
module eth_gen_assertions
	import eth_gen_pkg::*;
(
	input logic    clk,
	input logic    reset,
	input logic    tx_rdy,
	input word_t   tx_data,
	input logic    tx_wren,
	input logic    tx_sop,
	input logic    tx_eop,
	input tx_mod_t tx_mod
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;  // Failed assertions, summed into the closing line

	// Word and marks hold while the FIFO is not ready
	hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		(tx_wren && !tx_rdy) |=> (tx_wren && $stable(tx_data) && $stable(tx_sop)
			&& $stable(tx_eop) && $stable(tx_mod)))
		else
		begin
			$error("stream word or marks changed while tx_rdy was low");
			fail_count++;
		end

	marks_need_wren: assert property (@(posedge clk) disable iff (reset)
		(tx_sop || tx_eop) |-> tx_wren)
		else
		begin
			$error("sop or eop seen without tx_wren");
			fail_count++;
		end

	// Header alone is four words, so the two marks never share a word
	sop_not_eop: assert property (@(posedge clk) disable iff (reset) !(tx_sop && tx_eop))
		else
		begin
			$error("sop and eop on the same word");
			fail_count++;
		end

	// One empty cycle on the stream between frames
	gap_after_eop: assert property (@(posedge clk) disable iff (reset)
		(tx_wren && tx_rdy && tx_eop) |=> !tx_wren)
		else
		begin
			$error("tx_wren high right after the last word was accepted");
			fail_count++;
		end

endmodule

bind eth_gen eth_gen_assertions i_eth_gen_assertions (
	.clk(clk), .reset(reset), .tx_rdy(tx_rdy), .tx_data(tx_data),
	.tx_wren(tx_wren), .tx_sop(tx_sop), .tx_eop(tx_eop), .tx_mod(tx_mod)
);

//--- bench/eth_gen_checker.sv
// Stream and register checker that snoops the bus, rebuilds every frame and compares it with the DUT
module eth_gen_checker
	import eth_gen_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  reg_addr_t address,
	input  logic      write,
	input  logic      read,
	input  word_t     writedata,
	input  word_t     readdata,
	input  logic      tx_rdy,
	input  word_t     tx_data,
	input  logic      tx_wren,
	input  logic      tx_sop,
	input  logic      tx_eop,
	input  tx_mod_t   tx_mod,
	output int        frames_done,    // Frames accepted since start
	output logic      in_frame,
	output int        stream_errors,
	output int        reg_errors
);
	timeunit 1ns;
	timeprecision 100ps;

`include "eth_gen_macros.svh"

	word_t    regs [16];   // Raw words as written on the bus
	logic     stop_bit;
	logic     start_bit;
	logic     done_bit;
	int       frames_left; // Frames still due in this run
	int       widx;        // Word index within the frame
	int       plen;        // L of the frame on the stream
	seq_num_t seq;
	word_t    exp;
	tx_mod_t  mod;
	logic     last;

	assign in_frame = (widx != 0);

	// Bits of each register that hold a setting
	function automatic word_t write_mask(input reg_addr_t a);
		case (a)
			`REG_NUMBER_PACKET, `REG_SRC_LO, `REG_DST_LO: return 32'hFFFF_FFFF;
			`REG_CONFIG:                                   return 32'h0000_7FFE;
			`REG_SRC_HI, `REG_DST_HI:                      return 32'h0000_FFFF;
			default:                                       return 32'h0;
		endcase
	endfunction

	function automatic int payload_length(input logic [13:0] len);
		if (len < `LEN_HEADER_BYTES)
			return 0;
		if (len > `LEN_MAX_PROGRAM)
			return `LEN_MAX_PAYLOAD;
		return len - `LEN_HEADER_BYTES;
	endfunction

	// Bytes 0..5 destination, 6..11 source, low byte of the register first
	function automatic logic [7:0] header_byte(input int n);
		mac_addr_t a;
		if (n < 6)
			a = {regs[`REG_DST_HI][15:0], regs[`REG_DST_LO]};
		else
			a = {regs[`REG_SRC_HI][15:0], regs[`REG_SRC_LO]};
		return a[8 * (n % 6) +: 8];
	endfunction

	function automatic word_t expected_word(input int idx);
		word_t w;
		int    k;
		w = '0;
		k = (idx - 4) % 64;   // Byte pattern repeats every 256 bytes
		if (idx == 3)
			return {16'(plen + `LEN_FIELD_OFFSET), seq};
		for (int j = 0; j < 4; j++)
			w = {w[23:0], (idx < 3) ? header_byte(4 * idx + j) : 8'(4 * k + j)};
		return w;
	endfunction

	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			regs = '{default: '0};
			stop_bit = 1'b0;
			start_bit = 1'b0;
			done_bit = 1'b0;
			frames_left = 0;
			frames_done = 0;
			widx = 0;
			plen = 0;
			seq = '0;
			stream_errors = 0;
			reg_errors = 0;
		end
		else
		begin
			// Register reads
			// ----------------------------------------
			case (address)
				`REG_OPERATION:    exp = {29'd0, done_bit, stop_bit, start_bit};
				`REG_PACKET_COUNT: exp = frames_done;
				default:           exp = regs[address] & write_mask(address);
			endcase
			if (!read)
				exp = '0;        // Bus idles at zero
			if (readdata !== exp)
			begin
				reg_errors++;
				$display("FAIL %0t: read addr %0d read %b got %h expected %h",
					$time, address, read, readdata, exp);
			end

			// Stream words
			// ----------------------------------------
			if (tx_wren && (frames_left == 0) && (widx == 0))
			begin
				stream_errors++;
				$display("FAIL %0t: tx_wren high with no frame due", $time);
			end
			else if (tx_wren && tx_rdy)
			begin
				if (widx == 0)
					plen = payload_length(regs[`REG_CONFIG][14:1]);
				last = (widx == 3 + (plen + 3) / 4);
				exp = expected_word(widx);
				mod = last ? 2'((4 - plen % 4) % 4) : 2'd0;
				if (tx_data !== exp || tx_sop !== (widx == 0) || tx_eop !== last || tx_mod !== mod)
				begin
					stream_errors++;
					$display("FAIL %0t: frame %0d word %0d got %h %b%b%0d expected %h %b%b%0d",
						$time, frames_done, widx, tx_data, tx_sop, tx_eop, tx_mod,
						exp, widx == 0, last, mod);
				end
				widx++;
				if (last)
				begin
					widx = 0;
					frames_done++;
					seq++;
					frames_left = stop_bit ? 0 : frames_left - 1;  // Stop ends the run here
					if (frames_done == regs[`REG_NUMBER_PACKET])
						done_bit = 1'b1;
				end
			end

			// Bus writes
			// ----------------------------------------
			start_bit = 1'b0;
			if (write)
			begin
				regs[address] = writedata;
				if (address == `REG_OPERATION)
				begin
					stop_bit = writedata[1];
					if (writedata[0])
					begin
						start_bit = 1'b1;
						done_bit = 1'b0;
						frames_done = 0;
						seq = '0;
						widx = 0;
						frames_left = regs[`REG_NUMBER_PACKET];
					end
				end
			end
		end
	end

endmodule

//--- bench/eth_gen_tb.sv
// Testbench for the frame generator, random register programming, start/stop runs and watchdog
module eth_gen_tb
	import eth_gen_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

`include "eth_gen_macros.svh"

	localparam int NUM_RUNS = 6;
	localparam int FRAME_MAX = 4 + `LEN_MAX_PAYLOAD / 4 + 1;   // Longest frame plus its gap
	localparam int WATCHDOG_CYCLES = NUM_RUNS * 4 * FRAME_MAX * 8 + 5000;

	logic        clk = 1'b0;
	logic        reset;
	reg_addr_t   address;
	logic        write;
	logic        read;
	word_t       writedata;
	word_t       readdata;
	logic        tx_rdy;
	word_t       tx_data;
	logic        tx_wren;
	logic        tx_sop;
	logic        tx_eop;
	tx_mod_t     tx_mod;
	logic [31:0] lfsr;
	int          frames_done;
	logic        in_frame;
	int          stream_errors;
	int          reg_errors;
	int          kinds [NUM_RUNS] = '{0, 1, 0, 2, 3, 0};  // 0 normal 1 short 2 long 3 stopped

	always #5 clk = ~clk;

	eth_gen i_eth_gen (
		.clk(clk), .reset(reset), .address(address), .write(write), .read(read),
		.writedata(writedata), .readdata(readdata), .tx_rdy(tx_rdy), .tx_data(tx_data),
		.tx_wren(tx_wren), .tx_sop(tx_sop), .tx_eop(tx_eop), .tx_mod(tx_mod)
	);

	eth_gen_checker i_eth_gen_checker (
		.clk(clk), .reset(reset), .address(address), .write(write), .read(read),
		.writedata(writedata), .readdata(readdata), .tx_rdy(tx_rdy), .tx_data(tx_data),
		.tx_wren(tx_wren), .tx_sop(tx_sop), .tx_eop(tx_eop), .tx_mod(tx_mod),
		.frames_done(frames_done), .in_frame(in_frame),
		.stream_errors(stream_errors), .reg_errors(reg_errors)
	);

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic bus_write(input reg_addr_t a, input word_t d);
		@(negedge clk);
		address   = a;
		writedata = d;
		write     = 1'b1;
		@(negedge clk);
		write     = 1'b0;
	endtask

	task automatic bus_read(input reg_addr_t a);
		@(negedge clk);
		address = a;
		read    = 1'b1;
		@(negedge clk);
		read    = 1'b0;
	endtask

	// Programs one run, starts it and lets the stream drain under random back-pressure
	task automatic run_frames(input int kind);
		logic [13:0] len;
		int          npkt;
		int          target;
		logic        stop_sent;
		case (kind)
			1:       len = 14'(rand_bits(5) % 24);                        // Empty payload
			2:       len = 14'(`LEN_MAX_PROGRAM + 16'd1 + rand_bits(12)); // Clamped payload
			default: len = 14'(`LEN_HEADER_BYTES + rand_bits(8));
		endcase
		npkt   = (kind == 3) ? 4 : 1 + rand_bits(2);
		target = (kind == 3) ? 1 : npkt;
		bus_write(`REG_NUMBER_PACKET, npkt);
		bus_write(`REG_CONFIG, {17'd0, len, 1'b0});
		bus_write(`REG_SRC_LO, rand_bits(32));
		bus_write(`REG_SRC_HI, rand_bits(16));
		bus_write(`REG_DST_LO, rand_bits(32));
		bus_write(`REG_DST_HI, rand_bits(16));
		bus_write(`REG_OPERATION, 32'd1);   // Start, stop cleared
		stop_sent = 1'b0;
		while (frames_done < target)
		begin
			@(negedge clk);
			tx_rdy = (rand_bits(2) != 2'd0);  // Ready about 3/4 of the time
			write  = 1'b0;
			if ((kind == 3) && in_frame && !stop_sent)
			begin
				address   = `REG_OPERATION;
				writedata = 32'd2;                // Stop during the first frame
				write     = 1'b1;
				stop_sent = 1'b1;
			end
		end
		tx_rdy = 1'b1;
		repeat (20) @(negedge clk);           // Stream must stay quiet
		bus_read(`REG_PACKET_COUNT);
		bus_read(`REG_OPERATION);
	endtask

	initial
	begin
		reset     = 1'b1;
		address   = '0;
		write     = 1'b0;
		read      = 1'b0;
		writedata = '0;
		tx_rdy    = 1'b0;
		lfsr      = 32'hbf73efec;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Register readback
		// ----------------------------------------
		for (int a = 0; a < 16; a++)
			if (a != `REG_OPERATION)
				bus_write(reg_addr_t'(a), rand_bits(32));
		bus_write(`REG_OPERATION, rand_bits(32) & 32'hFFFF_FFFE);  // Bit 0 low, no start
		for (int a = 0; a < 16; a++)
			bus_read(reg_addr_t'(a));

		foreach (kinds[i])
			run_frames(kinds[i]);

		$display("Errors: stream %0d, register %0d, assertion %0d", stream_errors, reg_errors,
			i_eth_gen.i_eth_gen_assertions.fail_count);
		if (stream_errors + reg_errors + i_eth_gen.i_eth_gen_assertions.fail_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the runs did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+hw
hw/eth_gen_pkg.sv
hw/gen_regs.sv
hw/gen_fsm.sv
hw/frame_counters.sv
hw/frame_builder.sv
hw/eth_gen.sv
bench/eth_gen_assertions.sv
bench/eth_gen_checker.sv
bench/eth_gen_tb.sv
